//--- hw/subleq_pkg.sv
package subleq_pkg;

   // ------------------------------
   // Widths
   typedef logic [31:0] data_t;                  // Operand and register word
   typedef logic [31:0] addr_t;                  // Wishbone byte address
   typedef logic [3:0]  reg_idx_t;               // Micro register index
   typedef logic [5:0]  upc_t;                   // Micro PC and routine entry
   typedef logic [15:0] uop_t;                   // One micro-op
   typedef logic [7:0]  jump_t;                  // Signed relative jump

   localparam int    ROM_DEPTH = 64;
   localparam int    REG_COUNT = 16;
   localparam jump_t JUMP_END  = 8'hFF;          // Routine end marker

   // ------------------------------
   // Register map with unnamed slots as scratch
   localparam reg_idx_t TMP0 = 4'd0;
   localparam reg_idx_t SRC1 = 4'd2;             // First operand and result
   localparam reg_idx_t TMP1 = 4'd3;
   localparam reg_idx_t SRC2 = 4'd4;             // Second operand
   localparam reg_idx_t TMP2 = 4'd5;
   localparam reg_idx_t TMP3 = 4'd6;
   localparam reg_idx_t TMP4 = 4'd7;
   localparam reg_idx_t TMP5 = 4'd9;
   localparam reg_idx_t ONE  = 4'd10;
   localparam reg_idx_t WORD = 4'd11;
   localparam reg_idx_t INCR = 4'd12;
   localparam reg_idx_t NEXT = 4'd13;
   localparam reg_idx_t TMP6 = 4'd14;

   localparam data_t ONE_VAL  = 32'd1;
   localparam data_t WORD_VAL = 32'd31;
   localparam data_t INCR_VAL = 32'hFFFF_FFFF;   // -1
   localparam data_t NEXT_VAL = 32'hFFFF_FFFC;   // -4

   // Micro-op layout is A[15:12] B[11:8] jump[7:0]
   localparam int UOP_A_MSB    = 15;
   localparam int UOP_B_MSB    = 11;
   localparam int UOP_JUMP_MSB = 7;

   localparam addr_t OPB_OFFSET = 32'd4;
   localparam addr_t RES_OFFSET = 32'd8;

   localparam upc_t ENTRY_ADD    = 6'd0;
   localparam upc_t ENTRY_SUB    = 6'd16;
   localparam upc_t ENTRY_DOUBLE = 6'd32;

   typedef enum logic [2:0] {
      BUS_IDLE, BUS_FETCH_A, BUS_FETCH_B, BUS_RUN, BUS_WRITE
   } bus_state_e;

   typedef enum logic [1:0] {
      MICRO_IDLE, MICRO_FETCH, MICRO_EXECUTE, MICRO_WRITEBACK
   } micro_state_e;

endpackage

//--- hw/register_bank.sv
`timescale 1ns/1ns

module register_bank (
   input  logic                  clk,
   input  logic                  rst_n,
   // Micro read ports
   input  subleq_pkg::reg_idx_t  rd_a_idx_i,
   input  subleq_pkg::reg_idx_t  rd_b_idx_i,
   output subleq_pkg::data_t     rd_a_data_o,
   output subleq_pkg::data_t     rd_b_data_o,
   // Operand load from the bus side
   input  logic                  load_we_i,
   input  subleq_pkg::reg_idx_t  load_idx_i,
   input  subleq_pkg::data_t     load_data_i,
   // Micro writeback
   input  logic                  micro_we_i,
   input  subleq_pkg::reg_idx_t  micro_idx_i,
   input  subleq_pkg::data_t     micro_data_i,
   output subleq_pkg::data_t     result_o
);
   import subleq_pkg::*;

   data_t regs [REG_COUNT];

   // ------------------------------
   // Write side
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
         regs[ONE]  <= ONE_VAL;                  // Constants for the routines
         regs[WORD] <= WORD_VAL;
         regs[INCR] <= INCR_VAL;
         regs[NEXT] <= NEXT_VAL;
      end else if (load_we_i) begin
         regs[load_idx_i] <= load_data_i;        // Only outside a run
      end else if (micro_we_i) begin
         regs[micro_idx_i] <= micro_data_i;
      end
   end

   // ------------------------------
   // Registered reads with one cycle of latency
   always_ff @(posedge clk) begin
      rd_a_data_o <= regs[rd_a_idx_i];
      rd_b_data_o <= regs[rd_b_idx_i];
   end

   assign result_o = regs[SRC1];

endmodule

//--- hw/micro_sequencer.sv
`timescale 1ns/1ns

module micro_sequencer (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start_i,
   input  subleq_pkg::upc_t      entry_i,
   output subleq_pkg::reg_idx_t  rd_a_idx_o,
   output subleq_pkg::reg_idx_t  rd_b_idx_o,
   input  subleq_pkg::data_t     rd_a_data_i,
   input  subleq_pkg::data_t     rd_b_data_i,
   output logic                  micro_we_o,
   output subleq_pkg::reg_idx_t  micro_idx_o,
   output subleq_pkg::data_t     micro_data_o,
   output logic                  done_o
);
   import subleq_pkg::*;

   uop_t         rom [ROM_DEPTH];
   micro_state_e state_q;
   upc_t         upc_q;
   uop_t         uop_q;
   logic         done_q;
   reg_idx_t     b_idx;
   jump_t        jump;
   logic [32:0]  diff;
   logic         take_jump;
   logic         last_op;

   initial begin
      $readmemh("hw/microcode.hex", rom);
   end

   // ------------------------------
   // Micro-op fields
   assign rd_a_idx_o = uop_q[UOP_A_MSB -: $bits(reg_idx_t)];
   assign b_idx      = uop_q[UOP_B_MSB -: $bits(reg_idx_t)];
   assign rd_b_idx_o = b_idx;
   assign jump       = uop_q[UOP_JUMP_MSB -: $bits(jump_t)];
   assign last_op    = (jump == JUMP_END);

   // ------------------------------
   // SUBLEQ datapath for B <= B - A
   // One guard bit keeps the sign exact on overflow
   assign diff      = {rd_b_data_i[31], rd_b_data_i} - {rd_a_data_i[31], rd_a_data_i};
   assign take_jump = diff[32] | (diff == '0);   // Result <= 0

   assign micro_we_o   = (state_q == MICRO_WRITEBACK);
   assign micro_idx_o  = b_idx;
   assign micro_data_o = diff[31:0];
   assign done_o       = done_q;

   // Fetch a ROM word in the first phase only
   always_ff @(posedge clk) begin
      if (state_q == MICRO_FETCH) begin
         uop_q <= rom[upc_q];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= MICRO_IDLE;
         upc_q   <= '0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            MICRO_IDLE: begin
               if (start_i) begin
                  upc_q   <= entry_i;
                  state_q <= MICRO_FETCH;
               end
            end
            MICRO_FETCH: begin
               state_q <= MICRO_EXECUTE;         // Register read issued next
            end
            MICRO_EXECUTE: begin
               state_q <= MICRO_WRITEBACK;
            end
            MICRO_WRITEBACK: begin
               if (last_op) begin
                  state_q <= MICRO_IDLE;
                  done_q  <= 1'b1;               // Pulse after final write
               end else begin
                  state_q <= MICRO_FETCH;
                  // Truncating the jump keeps the sign modulo ROM size
                  if (take_jump) begin
                     upc_q <= upc_q + upc_t'(jump);
                  end else begin
                     upc_q <= upc_q + upc_t'(1);
                  end
               end
            end
         endcase
      end
   end

endmodule

//--- hw/bus_sequencer.sv
`timescale 1ns/1ns

module bus_sequencer (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cmd_valid_i,
   input  subleq_pkg::addr_t     cmd_addr_i,
   input  subleq_pkg::upc_t      cmd_entry_i,
   output logic                  cmd_ready_o,
   output logic                  wb_cyc_o,
   output logic                  wb_stb_o,
   output logic                  wb_we_o,
   output subleq_pkg::addr_t     wb_adr_o,
   output subleq_pkg::data_t     wb_dat_o,
   input  logic                  wb_ack_i,
   input  subleq_pkg::data_t     wb_dat_i,
   output logic                  micro_start_o,
   output subleq_pkg::upc_t      micro_entry_o,
   input  logic                  micro_done_i,
   input  subleq_pkg::data_t     result_i,
   output logic                  load_we_o,
   output subleq_pkg::reg_idx_t  load_idx_o,
   output subleq_pkg::data_t     load_data_o
);
   import subleq_pkg::*;

   bus_state_e state_q;
   bus_state_e state_d;
   addr_t      addr_q;
   upc_t       entry_q;
   data_t      wdata_q;
   logic       start_q;
   logic       cmd_fire;
   logic       rd_ack;

   // ------------------------------
   // Handshakes
   assign cmd_ready_o = (state_q == BUS_IDLE);
   assign cmd_fire    = cmd_valid_i & cmd_ready_o;
   assign rd_ack      = wb_ack_i & ((state_q == BUS_FETCH_A) | (state_q == BUS_FETCH_B));

   // ------------------------------
   // Wishbone outputs decoded from state
   assign wb_stb_o = (state_q == BUS_FETCH_A) | (state_q == BUS_FETCH_B) |
                     (state_q == BUS_WRITE);
   assign wb_cyc_o = wb_stb_o;                   // Single cycle per strobe
   assign wb_we_o  = (state_q == BUS_WRITE);
   assign wb_dat_o = wdata_q;

   always_comb begin
      case (state_q)
         BUS_FETCH_B: wb_adr_o = addr_q + OPB_OFFSET;
         BUS_WRITE:   wb_adr_o = addr_q + RES_OFFSET;
         default:     wb_adr_o = addr_q;         // Operand A and idle
      endcase
   end

   // Acked read data goes straight into the bank
   assign load_we_o   = rd_ack;
   assign load_idx_o  = (state_q == BUS_FETCH_A) ? SRC1 : SRC2;
   assign load_data_o = wb_dat_i;

   assign micro_start_o = start_q;
   assign micro_entry_o = entry_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         BUS_IDLE:    if (cmd_fire) state_d = BUS_FETCH_A;
         BUS_FETCH_A: if (wb_ack_i) state_d = BUS_FETCH_B;
         BUS_FETCH_B: if (wb_ack_i) state_d = BUS_RUN;
         BUS_RUN:     if (micro_done_i) state_d = BUS_WRITE;
         BUS_WRITE:   if (wb_ack_i) state_d = BUS_IDLE;
         default:     state_d = BUS_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= BUS_IDLE;
         start_q <= 1'b0;
      end else begin
         state_q <= state_d;
         start_q <= (state_q == BUS_FETCH_B) & wb_ack_i; // Both operands in place
      end
   end

   // Command and result payload
   always_ff @(posedge clk) begin
      if (cmd_fire) begin
         addr_q  <= cmd_addr_i;
         entry_q <= cmd_entry_i;
      end
      if ((state_q == BUS_RUN) && micro_done_i) begin
         wdata_q <= result_i;                    // SRC1 already holds the result
      end
   end

endmodule

//--- hw/subleq_top.sv
`timescale 1ns/1ns

module subleq_top (
   input  logic                 clk,
   input  logic                 rst_n,
   // Command port
   input  logic                 cmd_valid_i,
   input  subleq_pkg::addr_t    cmd_addr_i,
   input  subleq_pkg::upc_t     cmd_entry_i,
   output logic                 cmd_ready_o,
   // Wishbone master
   output logic                 wb_cyc_o,
   output logic                 wb_stb_o,
   output logic                 wb_we_o,
   output subleq_pkg::addr_t    wb_adr_o,
   output subleq_pkg::data_t    wb_dat_o,
   input  logic                 wb_ack_i,
   input  subleq_pkg::data_t    wb_dat_i
);
   import subleq_pkg::*;

   logic     micro_start;
   upc_t     micro_entry;
   logic     micro_done;
   logic     load_we;
   reg_idx_t load_idx;
   data_t    load_data;
   data_t    result;
   reg_idx_t rd_a_idx;
   reg_idx_t rd_b_idx;
   data_t    rd_a_data;
   data_t    rd_b_data;
   logic     micro_we;
   reg_idx_t micro_idx;
   data_t    micro_data;

   bus_sequencer i_bus_sequencer (
      .clk           (clk),
      .rst_n         (rst_n),
      .cmd_valid_i   (cmd_valid_i),
      .cmd_addr_i    (cmd_addr_i),
      .cmd_entry_i   (cmd_entry_i),
      .cmd_ready_o   (cmd_ready_o),
      .wb_cyc_o      (wb_cyc_o),
      .wb_stb_o      (wb_stb_o),
      .wb_we_o       (wb_we_o),
      .wb_adr_o      (wb_adr_o),
      .wb_dat_o      (wb_dat_o),
      .wb_ack_i      (wb_ack_i),
      .wb_dat_i      (wb_dat_i),
      .micro_start_o (micro_start),
      .micro_entry_o (micro_entry),
      .micro_done_i  (micro_done),
      .result_i      (result),
      .load_we_o     (load_we),
      .load_idx_o    (load_idx),
      .load_data_o   (load_data)
   );

   micro_sequencer i_micro_sequencer (
      .clk          (clk),
      .rst_n        (rst_n),
      .start_i      (micro_start),
      .entry_i      (micro_entry),
      .rd_a_idx_o   (rd_a_idx),
      .rd_b_idx_o   (rd_b_idx),
      .rd_a_data_i  (rd_a_data),
      .rd_b_data_i  (rd_b_data),
      .micro_we_o   (micro_we),
      .micro_idx_o  (micro_idx),
      .micro_data_o (micro_data),
      .done_o       (micro_done)
   );

   register_bank i_register_bank (
      .clk          (clk),
      .rst_n        (rst_n),
      .rd_a_idx_i   (rd_a_idx),
      .rd_b_idx_i   (rd_b_idx),
      .rd_a_data_o  (rd_a_data),
      .rd_b_data_o  (rd_b_data),
      .load_we_i    (load_we),
      .load_idx_i   (load_idx),
      .load_data_i  (load_data),
      .micro_we_i   (micro_we),
      .micro_idx_i  (micro_idx),
      .micro_data_i (micro_data),
      .result_o     (result)
   );

endmodule

//--- dv/subleq_checker.sv
`timescale 1ns/1ns

module subleq_checker (
   input logic              clk,
   input logic              rst_n,
   input logic              cmd_ready_i,
   input logic              wb_cyc_i,
   input logic              wb_stb_i,
   input logic              wb_we_i,
   input logic              wb_ack_i,
   input subleq_pkg::addr_t wb_adr_i,
   input subleq_pkg::data_t wb_dat_i
);
   int fail_count = 0;

   a_stb_is_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb_i == wb_cyc_i)
      else begin
         $error("Wishbone stb and cyc differ");
         fail_count++;
      end

   // Request held until the slave answers
   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_we_i) && $stable(wb_adr_i)
      && $stable(wb_dat_i))
      else begin
         $error("Wishbone request changed before ack");
         fail_count++;
      end

   a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !wb_stb_i && !wb_cyc_i)
      else begin
         $error("Wishbone strobe active right after reset");
         fail_count++;
      end

   a_busy: assert property (@(posedge clk) disable iff (!rst_n) wb_cyc_i |-> !cmd_ready_i)
      else begin
         $error("Command port ready during a bus cycle");
         fail_count++;
      end

endmodule

bind subleq_top subleq_checker i_checker (
   .clk         (clk),
   .rst_n       (rst_n),
   .cmd_ready_i (cmd_ready_o),
   .wb_cyc_i    (wb_cyc_o),
   .wb_stb_i    (wb_stb_o),
   .wb_we_i     (wb_we_o),
   .wb_ack_i    (wb_ack_i),
   .wb_adr_i    (wb_adr_o),
   .wb_dat_i    (wb_dat_o)
);

//--- dv/subleq_scoreboard.sv
`timescale 1ns/1ns

module subleq_scoreboard (
   input logic              clk,
   input logic              rst_n,
   input logic              cmd_valid_i,
   input logic              cmd_ready_i,
   input subleq_pkg::addr_t cmd_addr_i,
   input subleq_pkg::upc_t  cmd_entry_i,
   input logic              wb_cyc_i,
   input logic              wb_stb_i,
   input logic              wb_we_i,
   input logic              wb_ack_i,
   input subleq_pkg::addr_t wb_adr_i,
   input subleq_pkg::data_t wb_wdat_i,
   input subleq_pkg::data_t wb_rdat_i
);
   import subleq_pkg::*;

   uop_t       rom [ROM_DEPTH];
   addr_t      base;
   upc_t       entry;
   data_t      op_a;
   data_t      op_b;
   logic [1:0] got = 2'b00;                      // Operand reads seen for the command
   string      name = "none";
   logic       busy = 1'b0;
   int         checked = 0;
   int         errors = 0;

   initial begin
      $readmemh("hw/microcode.hex", rom);
   end

   // ------------------------------
   // Interpreter over the ROM image from the reset register values
   function automatic data_t reference(input upc_t start, input data_t a, input data_t b);
      data_t  r [16];
      upc_t   pc;
      uop_t   op;
      jump_t  j;
      longint diff;
      for (int i = 0; i < 16; i++) begin
         r[i] = '0;
      end
      r[ONE]  = 32'd1;
      r[WORD] = 32'd31;
      r[INCR] = 32'hFFFF_FFFF;
      r[NEXT] = 32'hFFFF_FFFC;
      r[SRC1] = a;
      r[SRC2] = b;
      pc = start;
      for (int step = 0; step < 1000; step++) begin
         op   = rom[pc];
         j    = op[7:0];
         diff = longint'($signed(r[op[11:8]])) - longint'($signed(r[op[15:12]]));
         r[op[11:8]] = data_t'(diff);
         if (j == 8'hFF) begin
            return r[SRC1];
         end
         if (diff <= 0) begin
            pc = upc_t'(int'(pc) + int'($signed(j)));
         end else begin
            pc = pc + 6'd1;
         end
      end
      return 'x;                                 // Routine never ended
   endfunction

   function automatic string routine_name(input upc_t e);
      case (e)
         ENTRY_ADD:    return "add";
         ENTRY_SUB:    return "sub";
         ENTRY_DOUBLE: return "double";
         default:      return "other";
      endcase
   endfunction

   task automatic check_write();
      data_t exp_data;
      logic  ok;
      exp_data = reference(entry, op_a, op_b);
      ok = 1'b1;
      if (got != 2'b11) begin
         $display("Operand reads missing before the result write of %s", name);
         ok = 1'b0;
      end
      if (wb_adr_i !== base + 32'd8) begin
         $display("Mismatch %s address: expected %h, actual %h", name, base + 32'd8, wb_adr_i);
         ok = 1'b0;
      end
      if (wb_wdat_i !== exp_data) begin
         $display("Mismatch %s data: expected %h, actual %h", name, exp_data, wb_wdat_i);
         ok = 1'b0;
      end
      if (ok) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: failed", name);
         errors++;
      end
      checked++;
      busy = 1'b0;
   endtask

   initial begin
      @(posedge rst_n);
      @(negedge clk);
      if (cmd_ready_i && !wb_cyc_i && !wb_stb_i && !wb_we_i) begin
         $display("reset_idle: ok");
      end else begin
         $display("Ports not idle after reset, ready %b cyc %b stb %b we %b",
                  cmd_ready_i, wb_cyc_i, wb_stb_i, wb_we_i);
         errors++;
      end
   end

   // ------------------------------
   // Bus watcher
   always @(posedge clk) begin
      if (rst_n && cmd_valid_i && cmd_ready_i) begin
         if (busy) begin
            $display("Command accepted while %s was still running", name);
            errors++;
         end
         busy  = 1'b1;
         got   = 2'b00;
         base  = cmd_addr_i;
         entry = cmd_entry_i;
         name  = $sformatf("%s_%0d", routine_name(cmd_entry_i), checked);
      end
      if (rst_n && wb_cyc_i && wb_stb_i && wb_ack_i) begin
         if (!wb_we_i) begin
            if (wb_adr_i == base) begin
               op_a   = wb_rdat_i;
               got[0] = 1'b1;
            end else if (wb_adr_i == base + 32'd4) begin
               op_b   = wb_rdat_i;
               got[1] = 1'b1;
            end else begin
               $display("Read from unexpected address %h during %s", wb_adr_i, name);
               errors++;
            end
         end else if (!busy) begin
            $display("Write to %h with no command in progress", wb_adr_i);
            errors++;
         end else begin
            check_write();
         end
      end
   end

endmodule

//--- dv/tb_subleq.sv
`timescale 1ns/1ns

module tb_subleq;
   import subleq_pkg::*;

   localparam int TEST_COUNT  = 24;
   localparam int CYCLE_LIMIT = TEST_COUNT * 300;

   logic  clk;
   logic  rst_n;
   logic  cmd_valid_i;
   addr_t cmd_addr_i;
   upc_t  cmd_entry_i;
   logic  cmd_ready_o;
   logic  wb_cyc_o;
   logic  wb_stb_o;
   logic  wb_we_o;
   addr_t wb_adr_o;
   data_t wb_dat_o;
   logic  wb_ack_i;
   data_t wb_dat_i;

   data_t mem [addr_t];                          // Sparse Wishbone memory
   upc_t  entries [3] = '{ENTRY_ADD, ENTRY_SUB, ENTRY_DOUBLE};
   int    ack_wait = -1;                         // -1 when no transfer is timed
   int    test_index = 0;
   int    cycles = 0;

   subleq_top i_dut (.*);

   subleq_scoreboard i_scoreboard (
      .clk         (clk),
      .rst_n       (rst_n),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_i (cmd_ready_o),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_entry_i (cmd_entry_i),
      .wb_cyc_i    (wb_cyc_o),
      .wb_stb_i    (wb_stb_o),
      .wb_we_i     (wb_we_o),
      .wb_ack_i    (wb_ack_i),
      .wb_adr_i    (wb_adr_o),
      .wb_wdat_i   (wb_dat_o),
      .wb_rdat_i   (wb_dat_i)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   // ------------------------------
   // Memory model acks after 0 to 3 extra cycles
   function automatic data_t read_word(input addr_t adr);
      if (mem.exists(adr)) begin
         return mem[adr];
      end
      return adr ^ 32'h5A5A_A5A5;                // Unwritten words
   endfunction

   always @(negedge clk) begin
      if (wb_ack_i) begin
         wb_ack_i = 1'b0;                        // Transfer ended at the last edge
         ack_wait = -1;
      end else if (wb_stb_o) begin
         if (ack_wait < 0) begin
            ack_wait = $urandom_range(3, 0);
         end
         if (ack_wait == 0) begin
            wb_ack_i = 1'b1;
            if (wb_we_o) begin
               mem[wb_adr_o] = wb_dat_o;
            end else begin
               wb_dat_i = read_word(wb_adr_o);
            end
         end else begin
            ack_wait--;
         end
      end
   end

   // Returns once the command is accepted, so the next one overlaps the run
   task automatic run_test(input upc_t entry, input data_t a, input data_t b);
      addr_t base;
      base = 32'h0000_1000 + 32'(test_index) * 32'h10;
      test_index++;
      mem[base] = a;
      mem[base + 32'd4] = b;
      @(negedge clk);
      cmd_valid_i = 1'b1;
      cmd_addr_i  = base;
      cmd_entry_i = entry;
      while (!cmd_ready_o) begin
         @(negedge clk);
      end
      @(negedge clk);
      cmd_valid_i = 1'b0;
   endtask

   initial begin
      void'($urandom(23));
      clk         = 1'b0;
      rst_n       = 1'b0;
      cmd_valid_i = 1'b0;
      cmd_addr_i  = '0;
      cmd_entry_i = '0;
      wb_ack_i    = 1'b0;
      wb_dat_i    = '0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      repeat (2) @(negedge clk);

      repeat (6) run_test(ENTRY_ADD, $urandom(), $urandom());
      // Sub across zero and at the signed extremes
      run_test(ENTRY_SUB, 32'd5, 32'd7);
      run_test(ENTRY_SUB, 32'd0, 32'd1);
      run_test(ENTRY_SUB, 32'hFFFF_FFFD, 32'hFFFF_FFFD);
      run_test(ENTRY_SUB, 32'h8000_0000, 32'd1);
      run_test(ENTRY_SUB, 32'h7FFF_FFFF, 32'hFFFF_FFFF);
      run_test(ENTRY_SUB, 32'd0, 32'h8000_0000);
      run_test(ENTRY_DOUBLE, 32'd21, $urandom());
      run_test(ENTRY_DOUBLE, 32'hFFFF_FFF0, 32'd0);
      run_test(ENTRY_DOUBLE, 32'h8000_0000, 32'd0);
      run_test(ENTRY_DOUBLE, $urandom(), $urandom());
      // Mixed routines back to back
      repeat (8) run_test(entries[$urandom_range(2, 0)], $urandom(), $urandom());

      wait (i_scoreboard.checked == TEST_COUNT);
      @(negedge clk);
      $display("Summary: %0d of %0d tests checked, %0d errors, %0d assertion failures",
               i_scoreboard.checked, TEST_COUNT, i_scoreboard.errors,
               i_dut.i_checker.fail_count);
      if (i_scoreboard.errors == 0 && i_dut.i_checker.fail_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- hw/microcode.hex
// Microcode ROM, one 16-bit micro-op per word
// Fields A[15:12] B[11:8] jump[7:0]; B <= B - A, jump FF ends the routine
@00
// add: TMP0 <= -SRC2, SRC1 <= SRC1 - TMP0, clear TMP0
4001
0201
00FF
@10
// sub: SRC1 <= SRC1 - SRC2
42FF
@20
// double: TMP0 <= -SRC1, clear SRC1, TMP1 counts two passes
2001
2201
C301
C301
// Loop body, add A, count down, jump back by two
0201
A302
77FE
// Exit, clear TMP0
00FF

//--- subleq_unit.f
hw/subleq_pkg.sv
hw/register_bank.sv
hw/micro_sequencer.sv
hw/bus_sequencer.sv
hw/subleq_top.sv
dv/subleq_checker.sv
dv/subleq_scoreboard.sv
dv/tb_subleq.sv

//--- run.sh
#!/bin/sh
# Build and run the SUBLEQ unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_subleq \
   -f subleq_unit.f -o sim_subleq
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_subleq +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
   exit 0
fi
exit 1
